/* build.f */
common/procPkg.sv
common/pipeIfs.sv
pipeline/fetchStage.sv
pipeline/decodeStage.sv
pipeline/executeStage.sv
pipeline/memStage.sv
memory/memArbiter.sv
memory/unifiedMem.sv
source/procTop.sv
dv/tbClock.sv
dv/procTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -j 0
TOP ?= procTb
FILELIST ?= build.f
OBJDIR ?= obj_dir
SIM = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -x "TEST PASS" > /dev/null

clean:
	rm -rf $(OBJDIR)

/* dv/procTb.sv */
// Assumes registers and memory start at zero; data accesses use r7 as base, kept at zero
`timescale 1ns/1ps

module procTb;
	import procPkg::*;

	localparam int NumTests = 6;
	localparam int ResetCycles = 10;
	localparam int LoadWords = 64;
	localparam int MaxBody = 40;
	localparam int StallMargin = 8;
	localparam int QuietCycles = 20;
	localparam int ClkPeriod = 20;
	localparam int CyclesPerTest = ResetCycles + LoadWords +
		(MaxBody + 1) * StallMargin + QuietCycles;

	logic clk;
	logic rst;
	logic loadEn;
	word_t loadAddr;
	word_t loadData;
	logic err;
	logic halted;
	logic wbEn;
	regAddr_t wbReg;
	word_t wbData;

	integer seed;
	int testErrors;
	int checkErrors;
	int passCount;
	int failCount;
	word_t prog[$];
	word_t modelMem[MemWords];
	word_t modelRegs[RegCount];
	regAddr_t expReg[$];
	word_t expData[$];

	tbClock u_tbClock (.clk(clk));

	procTop u_procTop (
		.clk(clk),
		.rst(rst),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.err(err),
		.halted(halted),
		.wbEn(wbEn),
		.wbReg(wbReg),
		.wbData(wbData)
	);

	function automatic int pick(int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic word_t encode(logic [3:0] op, int rd, int rs, int low6);
		return {op, rd[2:0], rs[2:0], low6[5:0]};
	endfunction

	task automatic checkValue(string name, logic [31:0] got, logic [31:0] expected);
		if (got !== expected) begin
			$display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, expected);
			testErrors++;
			checkErrors++;
		end
	endtask

	task automatic reportFailure(string msg);
		$display("Error at %0t: %s", $time, msg);
		testErrors++;
		checkErrors++;
	endtask

	// Body of n instructions, then HALT; branches jump forward at most to the HALT
	task automatic genProgram(int n, bit useMem, bit useBranch, int undefPos);
		int kind;
		int lastRd;
		int rd;
		int rs;
		lastRd = 0;
		prog.delete();
		for (int i = 0; i < n; i++) begin
			kind = pick(10);
			rd = pick(7);
			rs = pick(2) ? lastRd : pick(8);
			if (i == undefPos) begin
				prog.push_back(encode(4'(11 + pick(5)), pick(8), pick(8), pick(64)));
			end else if (kind >= 6 && kind <= 7 && useMem) begin
				if (pick(2))
					prog.push_back(encode(OpSt, pick(8), 7, -2 * (1 + pick(16))));
				else
					prog.push_back(encode(OpLd, rd, 7, -2 * (1 + pick(16))));
			end else if (kind >= 8 && useBranch) begin
				prog.push_back(encode(pick(2) ? OpBeqz : OpBnez, 0, rs,
					pick(((n - 1 - i) < 3 ? (n - 1 - i) : 3) + 1)));
			end else if (kind == 5 && useBranch) begin
				prog.push_back(encode(OpXor, rd, rd, rd << 3));
			end else if (kind == 4) begin
				prog.push_back(encode(OpAddi, rd, rs, pick(64)));
			end else begin
				prog.push_back(encode(4'(OpAdd + pick(4)), rd, rs, pick(8) << 3));
			end
			if (i != undefPos)
				lastRd = rd;
		end
		prog.push_back(encode(OpHalt, 0, 0, 0));
	endtask

	// Architectural model, one instruction at a time
	task automatic runModel();
		word_t pc;
		word_t w;
		word_t imm;
		word_t addr;
		word_t a;
		word_t b;
		word_t pcNext;
		regAddr_t rd;
		int steps;
		bit done;
		for (int i = 0; i < LoadWords; i++)
			modelMem[i] = (i < prog.size()) ? prog[i] : 16'h0000;
		expReg.delete();
		expData.delete();
		pc = '0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 4 * LoadWords) begin
			w = modelMem[pc[8:1]];
			imm = {{10{w[5]}}, w[5:0]};
			rd = w[11:9];
			a = modelRegs[w[8:6]];
			b = modelRegs[w[5:3]];
			pcNext = pc + 16'd2;
			case (w[15:12])
				4'h0: done = 1'b1;
				4'h2, 4'h3, 4'h4, 4'h5, 4'h6: begin
					case (w[15:12])
						4'h2: modelRegs[rd] = a + b;
						4'h3: modelRegs[rd] = a - b;
						4'h4: modelRegs[rd] = a & b;
						4'h5: modelRegs[rd] = a ^ b;
						default: modelRegs[rd] = a + imm;
					endcase
					expReg.push_back(rd);
					expData.push_back(modelRegs[rd]);
				end
				4'h7: begin
					addr = a + imm;
					modelRegs[rd] = modelMem[addr[8:1]];
					expReg.push_back(rd);
					expData.push_back(modelRegs[rd]);
				end
				4'h8: begin
					addr = a + imm;
					modelMem[addr[8:1]] = modelRegs[rd];
				end
				4'h9: if (a == 0) pcNext = pcNext + (imm << 1);
				4'hA: if (a != 0) pcNext = pcNext + (imm << 1);
				default: ;
			endcase
			pc = pcNext;
			steps++;
		end
	endtask

	task automatic runTest(string name, bit expectErr);
		int idx;
		bit done;
		bit errRose;
		testErrors = 0;
		runModel();
		@(negedge clk);
		rst = 1'b1;
		repeat (ResetCycles) @(negedge clk);
		for (int i = 0; i < LoadWords; i++) begin
			loadEn = 1'b1;
			loadAddr = word_t'(i * 2);
			loadData = (i < prog.size()) ? prog[i] : 16'h0000;
			@(negedge clk);
		end
		loadEn = 1'b0;
		rst = 1'b0;
		@(negedge clk);
		checkValue("wbEn", 32'(wbEn), 0);
		checkValue("halted", 32'(halted), 0);
		checkValue("err", 32'(err), 0);
		idx = 0;
		done = 1'b0;
		errRose = 1'b0;
		while (!done) begin
			if (wbEn) begin
				if (idx < expReg.size()) begin
					checkValue("wbReg", 32'(wbReg), 32'(expReg[idx]));
					checkValue("wbData", 32'(wbData), 32'(expData[idx]));
				end else begin
					reportFailure($sformatf("unexpected write-back to r%0d", wbReg));
				end
				idx++;
			end
			if (err)
				errRose = 1'b1;
			else if (errRose)
				reportFailure("err dropped before reset");
			if (halted)
				done = 1'b1;
			else
				@(negedge clk);
		end
		repeat (QuietCycles) begin
			@(negedge clk);
			if (wbEn)
				reportFailure("write-back after halted rose");
			checkValue("halted", 32'(halted), 1);
			if (errRose && !err)
				reportFailure("err dropped before reset");
		end
		checkValue("trace length", idx, expReg.size());
		checkValue("err", 32'(err), 32'(expectErr));
		if (testErrors == 0)
			passCount++;
		else
			failCount++;
		$display("%s: %s, %0d write-backs, %0d errors", name,
			(testErrors == 0) ? "ok" : "failed", idx, testErrors);
	endtask

	initial begin
		#(NumTests * CyclesPerTest * ClkPeriod);
		$display("Watchdog expired before all tests finished");
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		seed = 76;
		rst = 1'b1;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		checkErrors = 0;
		passCount = 0;
		failCount = 0;
		for (int i = 0; i < MemWords; i++)
			modelMem[i] = '0;
		for (int i = 0; i < RegCount; i++)
			modelRegs[i] = '0;

		genProgram(0, 1'b0, 1'b0, -1);
		runTest("halt only", 1'b0);
		genProgram(30, 1'b0, 1'b0, -1);
		runTest("alu chain", 1'b0);
		genProgram(36, 1'b1, 1'b0, -1);
		runTest("load store", 1'b0);
		genProgram(36, 1'b0, 1'b1, -1);
		runTest("branches", 1'b0);
		genProgram(MaxBody, 1'b1, 1'b1, -1);
		runTest("mixed", 1'b0);
		genProgram(20, 1'b0, 1'b0, pick(20));
		runTest("undefined opcode", 1'b1);

		$display("Tests passed %0d, failed %0d, check errors %0d", passCount, failCount,
			checkErrors);
		if (failCount == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

/* dv/tbClock.sv */
// Free-running clock with a 20 ns period, low at time zero
`timescale 1ns/1ps

module tbClock #(
	parameter int HalfPeriod = 10
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(HalfPeriod) clk = ~clk;
	end

endmodule

/* source/procTop.sv */
// Program loads through loadEn only while rst is high; halted and err stay set until rst
`timescale 1ns/1ps

module procTop (
	input logic clk,
	input logic rst,
	input logic loadEn,
	input procPkg::word_t loadAddr,
	input procPkg::word_t loadData,
	output logic err,
	output logic halted,
	output logic wbEn,
	output procPkg::regAddr_t wbReg,
	output procPkg::word_t wbData
);

	memBusIf instBus ();
	memBusIf dataBus ();
	memBusIf memBus ();
	fetchDecIf fdBus ();
	decExIf deBus ();
	exMemIf emBus ();
	wbIf wbBus ();

	fetchStage u_fetchStage (
		.clk(clk),
		.rst(rst),
		.mem(instBus),
		.dec(fdBus)
	);

	// Pending destinations are the instructions now in execute and in memory stage
	decodeStage u_decodeStage (
		.clk(clk),
		.rst(rst),
		.fd(fdBus),
		.de(deBus),
		.wb(wbBus),
		.exDest(deBus.dest),
		.exRegWrite(deBus.regWrite),
		.memDest(emBus.dest),
		.memRegWrite(emBus.regWrite),
		.err(err)
	);

	executeStage u_executeStage (
		.clk(clk),
		.rst(rst),
		.de(deBus),
		.em(emBus)
	);

	memStage u_memStage (
		.clk(clk),
		.rst(rst),
		.em(emBus),
		.mem(dataBus),
		.wb(wbBus)
	);

	memArbiter u_memArbiter (
		.clk(clk),
		.rst(rst),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.data(dataBus),
		.inst(instBus),
		.mem(memBus)
	);

	unifiedMem u_unifiedMem (
		.clk(clk),
		.bus(memBus)
	);

	assign wbEn = wbBus.en;
	assign wbReg = wbBus.dest;
	assign wbData = wbBus.data;
	assign halted = wbBus.halt;

endmodule

/* memory/unifiedMem.sv */
// Word array without reset; byte address bit 0 and bits above the index are ignored
`timescale 1ns/1ps

module unifiedMem (
	input logic clk,
	memBusIf.store bus
);
	import procPkg::*;

	word_t words [MemWords];
	memIdx_t idx;

	assign idx = bus.addr[IdxMsb:IdxLsb];

	assign bus.rdata = words[idx];

	always_ff @(posedge clk) begin
		if (bus.req && bus.we) begin
			words[idx] <= bus.wdata;
		end
	end

endmodule

/* memory/memArbiter.sv */
// Load port wins over data, data over instruction; instruction reads start the cycle after rst
`timescale 1ns/1ps

module memArbiter (
	input logic clk,
	input logic rst,
	input logic loadEn,
	input procPkg::word_t loadAddr,
	input procPkg::word_t loadData,
	memBusIf.server data,
	memBusIf.server inst,
	memBusIf.client mem
);

	logic instEnable;
	logic dataSel;
	logic instSel;

	// Keeps fetch off the bus while a program may still be loading
	always_ff @(posedge clk) begin
		if (rst) begin
			instEnable <= 1'b0;
		end else begin
			instEnable <= 1'b1;
		end
	end

	assign dataSel = ~loadEn & data.req;
	assign instSel = ~loadEn & ~data.req & inst.req & instEnable;

	assign data.grant = dataSel;
	assign inst.grant = instSel;

	assign mem.req = loadEn | dataSel | instSel;

	always_comb begin
		if (loadEn) begin
			mem.we = 1'b1;
			mem.addr = loadAddr;
			mem.wdata = loadData;
		end else if (dataSel) begin
			mem.we = data.we;
			mem.addr = data.addr;
			mem.wdata = data.wdata;
		end else begin
			mem.we = inst.we;
			mem.addr = inst.addr;
			mem.wdata = inst.wdata;
		end
	end

	assign data.rdata = mem.rdata;
	assign inst.rdata = mem.rdata;

endmodule

/* pipeline/memStage.sv */
// Assumes the data request is always granted in its own cycle, so this stage never waits
`timescale 1ns/1ps

module memStage (
	input logic clk,
	input logic rst,
	exMemIf.sink em,
	memBusIf.client mem,
	wbIf.source wb
);
	import procPkg::*;

	logic isLoad;
	logic haltSeen;

	assign isLoad = em.op == OpLd;

	assign mem.req = em.valid & (isLoad | em.op == OpSt);
	assign mem.we = em.op == OpSt;
	assign mem.addr = em.result;
	assign mem.wdata = em.storeData;

	assign wb.halt = haltSeen;

	always_ff @(posedge clk) begin
		if (rst) begin
			haltSeen <= 1'b0;
			wb.en <= 1'b0;
		end else begin
			haltSeen <= haltSeen | (em.valid & em.op == OpHalt);
			wb.en <= em.regWrite;
		end
	end

	always_ff @(posedge clk) begin
		wb.dest <= em.dest;
		wb.data <= isLoad ? mem.rdata : em.result;
	end

endmodule

/* pipeline/executeStage.sv */
// Single-cycle ALU; loads and stores share the adder for base plus offset
`timescale 1ns/1ps

module executeStage (
	input logic clk,
	input logic rst,
	decExIf.sink de,
	exMemIf.source em
);
	import procPkg::*;

	word_t result;

	always_comb begin
		case (de.op)
			OpSub: result = de.opA - de.opB;
			OpAnd: result = de.opA & de.opB;
			OpXor: result = de.opA ^ de.opB;
			OpAdd, OpAddi, OpLd, OpSt: result = de.opA + de.opB;
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			em.valid <= 1'b0;
			em.regWrite <= 1'b0;
		end else begin
			em.valid <= de.valid;
			em.regWrite <= de.valid & de.regWrite;
		end
	end

	always_ff @(posedge clk) begin
		em.op <= de.op;
		em.dest <= de.dest;
		em.result <= result;
		em.storeData <= de.storeData;
	end

endmodule

/* pipeline/decodeStage.sv */
// Has no forwarding and stalls until a source leaves the memory stage; a HALT stops issue until rst
`timescale 1ns/1ps

module decodeStage (
	input logic clk,
	input logic rst,
	fetchDecIf.decode fd,
	decExIf.source de,
	wbIf.sink wb,
	input procPkg::regAddr_t exDest,
	input logic exRegWrite,
	input procPkg::regAddr_t memDest,
	input logic memRegWrite,
	output logic err
);
	import procPkg::*;

	word_t regs [RegCount];
	opcode_t op;
	regAddr_t rd;
	regAddr_t rs;
	regAddr_t rt;
	word_t immExt;
	word_t srcA;
	word_t srcB;
	word_t srcD;
	logic useRs;
	logic useRt;
	logic useRd;
	logic writesReg;
	logic immOperand;
	logic undefOp;
	logic isHalt;
	logic hazard;
	logic issue;
	logic taken;
	logic stopped;
	logic errSeen;

	// Write-back in this cycle is visible to the read
	function automatic word_t readReg(regAddr_t a);
		return (wb.en && wb.dest == a) ? wb.data : regs[a];
	endfunction

	function automatic logic pending(regAddr_t a);
		return (exRegWrite && exDest == a) || (memRegWrite && memDest == a);
	endfunction

	assign op = opcode_t'(fd.instr[OpMsb:OpLsb]);
	assign rd = fd.instr[RdMsb:RdLsb];
	assign rs = fd.instr[RsMsb:RsLsb];
	assign rt = fd.instr[RtMsb:RtLsb];
	assign immExt = {{(WordBits - ImmMsb - 1){fd.instr[ImmMsb]}}, fd.instr[ImmMsb:ImmLsb]};

	assign srcA = readReg(rs);
	assign srcB = readReg(rt);
	assign srcD = readReg(rd);

	always_comb begin
		useRs = 1'b0;
		useRt = 1'b0;
		useRd = 1'b0;
		writesReg = 1'b0;
		immOperand = 1'b0;
		undefOp = 1'b0;
		isHalt = 1'b0;
		case (op)
			OpAdd, OpSub, OpAnd, OpXor: begin
				useRs = 1'b1;
				useRt = 1'b1;
				writesReg = 1'b1;
			end
			OpAddi, OpLd: begin
				useRs = 1'b1;
				immOperand = 1'b1;
				writesReg = 1'b1;
			end
			// Store data comes from the rd field
			OpSt: begin
				useRs = 1'b1;
				useRd = 1'b1;
				immOperand = 1'b1;
			end
			OpBeqz, OpBnez: useRs = 1'b1;
			OpHalt: isHalt = 1'b1;
			OpNop: writesReg = 1'b0;
			default: undefOp = 1'b1;
		endcase
	end

	assign hazard = fd.valid & ((useRs & pending(rs)) | (useRt & pending(rt)) |
		(useRd & pending(rd)));
	assign issue = fd.valid & ~hazard & ~stopped & ~undefOp;
	assign taken = issue & ((op == OpBeqz && srcA == '0) || (op == OpBnez && srcA != '0));

	assign fd.stall = hazard | stopped | (issue & isHalt);
	assign fd.flush = taken;
	assign fd.target = fd.pcNext + (immExt << 1);

	assign err = errSeen | (fd.valid & undefOp);

	always_ff @(posedge clk) begin
		if (wb.en) begin
			regs[wb.dest] <= wb.data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			stopped <= 1'b0;
			errSeen <= 1'b0;
			de.valid <= 1'b0;
			de.regWrite <= 1'b0;
		end else begin
			stopped <= stopped | (issue & isHalt);
			errSeen <= errSeen | (fd.valid & undefOp);
			de.valid <= issue;
			de.regWrite <= issue & writesReg;
		end
	end

	always_ff @(posedge clk) begin
		de.op <= op;
		de.dest <= rd;
		de.opA <= srcA;
		de.opB <= immOperand ? immExt : srcB;
		de.storeData <= srcD;
	end

endmodule

/* pipeline/fetchStage.sv */
// Reads instructions only; the PC holds while decode stalls and while the bus is not granted
`timescale 1ns/1ps

module fetchStage (
	input logic clk,
	input logic rst,
	memBusIf.client mem,
	fetchDecIf.fetch dec
);
	import procPkg::*;

	word_t pc;
	word_t pcPlusTwo;

	assign pcPlusTwo = pc + 16'd2;

	// No request while decode holds us or throws the fetched word away
	assign mem.req = ~dec.stall & ~dec.flush;
	assign mem.we = 1'b0;
	assign mem.addr = pc;
	assign mem.wdata = '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			dec.valid <= 1'b0;
		end else if (dec.flush) begin
			pc <= dec.target;
			dec.valid <= 1'b0;
		end else if (!dec.stall) begin
			dec.valid <= mem.grant;
			if (mem.grant) begin
				pc <= pcPlusTwo;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (dec.flush || (!dec.stall && !mem.grant)) begin
			dec.instr <= NopInstr;
		end else if (!dec.stall) begin
			dec.instr <= mem.rdata;
			dec.pcNext <= pcPlusTwo;
		end
	end

endmodule

/* common/pipeIfs.sv */
// Memory bus access happens when req and grant are both high, read data is valid in that cycle
`timescale 1ns/1ps

interface memBusIf;
	import procPkg::*;

	logic req;
	logic we;
	word_t addr;
	word_t wdata;
	word_t rdata;
	logic grant;

	modport client (output req, we, addr, wdata, input rdata, grant);
	modport server (input req, we, addr, wdata, output rdata, grant);
	modport store (input req, we, addr, wdata, output rdata);
endinterface

interface fetchDecIf;
	import procPkg::*;

	logic valid;
	word_t instr;
	word_t pcNext;
	// Back from decode
	logic stall;
	logic flush;
	word_t target;

	modport fetch (output valid, instr, pcNext, input stall, flush, target);
	modport decode (input valid, instr, pcNext, output stall, flush, target);
endinterface

interface decExIf;
	import procPkg::*;

	logic valid;
	opcode_t op;
	regAddr_t dest;
	logic regWrite;
	word_t opA;
	word_t opB;
	word_t storeData;

	modport source (output valid, op, dest, regWrite, opA, opB, storeData);
	modport sink (input valid, op, dest, regWrite, opA, opB, storeData);
endinterface

interface exMemIf;
	import procPkg::*;

	logic valid;
	opcode_t op;
	regAddr_t dest;
	logic regWrite;
	word_t result;
	word_t storeData;

	modport source (output valid, op, dest, regWrite, result, storeData);
	modport sink (input valid, op, dest, regWrite, result, storeData);
endinterface

interface wbIf;
	import procPkg::*;

	logic en;
	regAddr_t dest;
	word_t data;
	logic halt;

	modport source (output en, dest, data, halt);
	modport sink (input en, dest, data);
endinterface

/* common/procPkg.sv */
// 16-bit words over a 256-word memory addressed in bytes; opcodes 4'hB to 4'hF are undefined
package procPkg;

	localparam int WordBits = 16;
	localparam int RegCount = 8;
	localparam int MemWords = 256;

	typedef logic [WordBits-1:0] word_t;
	typedef logic [2:0] regAddr_t;
	typedef logic [7:0] memIdx_t;

	// A zero word decodes as HALT
	typedef enum logic [3:0] {
		OpHalt = 4'h0,
		OpNop  = 4'h1,
		OpAdd  = 4'h2,
		OpSub  = 4'h3,
		OpAnd  = 4'h4,
		OpXor  = 4'h5,
		OpAddi = 4'h6,
		OpLd   = 4'h7,
		OpSt   = 4'h8,
		OpBeqz = 4'h9,
		OpBnez = 4'hA
	} opcode_t;

	localparam int OpMsb = 15;
	localparam int OpLsb = 12;
	localparam int RdMsb = 11;
	localparam int RdLsb = 9;
	localparam int RsMsb = 8;
	localparam int RsLsb = 6;
	localparam int RtMsb = 5;
	localparam int RtLsb = 3;
	localparam int ImmMsb = 5;
	localparam int ImmLsb = 0;

	// Word index inside a byte address
	localparam int IdxMsb = 8;
	localparam int IdxLsb = 1;

	localparam word_t NopInstr = {OpNop, 12'h000};

endpackage
